//--- hdl/soc_bus_pkg.sv
package soc_bus_pkg;

  //////////////////////////////
  // Widths with a meaning
  //////////////////////////////

  // Byte address on the bus
  typedef logic [31:0] addr_t;
  // One bus data word
  typedef logic [31:0] data_t;
  // Byte enables, all zero for a read
  typedef logic [3:0]  strb_t;
  // Word index into the main RAM
  typedef logic [15:0] ram_word_t;

  //////////////////////////////
  // Bus structs
  //////////////////////////////

  // Master to slave, held stable until ready
  typedef struct packed {
    logic  valid;
    strb_t wstrb;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Slave to master, rdata and err meaningful only with ready
  typedef struct packed {
    logic  ready;
    logic  err;
    data_t rdata;
  } bus_rsp_t;

  // Loader write into the RAM
  typedef struct packed {
    logic      en;
    ram_word_t word;
    data_t     data;
  } ram_wr_t;

  // Decoded target of a request
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_TIMER_LO,
    TGT_TIMER_HI,
    TGT_NONE
  } target_e;

  //////////////////////////////
  // Address map
  //////////////////////////////

  // RAM window, 1 MB
  localparam addr_t RAM_BASE      = 32'h4000_0000;
  localparam addr_t RAM_MASK      = 32'h000F_FFFF;
  // Timer halves
  localparam addr_t TIMER_LO_ADDR = 32'h3000_0000;
  localparam addr_t TIMER_HI_ADDR = 32'h3000_0004;

  // First byte of a load frame
  localparam logic [7:0] LOAD_SYNC = 8'h5A;

endpackage

//--- hdl/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder import soc_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n,
  input  bus_req_t bus_req_i,
  output logic     ram_sel_o,
  output logic     timer_sel_o,
  output logic     timer_hi_o,
  input  bus_rsp_t ram_rsp_i,
  input  bus_rsp_t timer_rsp_i,
  output bus_rsp_t bus_rsp_o
);

  target_e tgt;
  // Pending error response for an unmapped address
  logic    err_q;

  //////////////////////////////
  // Address classification
  //////////////////////////////

  always_comb begin
    // RAM window first, then the two exact timer addresses
    if ((bus_req_i.addr & ~RAM_MASK) == RAM_BASE) begin
      tgt = TGT_RAM;
    end else if (bus_req_i.addr == TIMER_LO_ADDR) begin
      tgt = TGT_TIMER_LO;
    end else if (bus_req_i.addr == TIMER_HI_ADDR) begin
      tgt = TGT_TIMER_HI;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // Selects follow valid, targets see the shared request
  assign ram_sel_o   = bus_req_i.valid && (tgt == TGT_RAM);
  assign timer_sel_o = bus_req_i.valid && (tgt == TGT_TIMER_LO || tgt == TGT_TIMER_HI);
  assign timer_hi_o  = (tgt == TGT_TIMER_HI);

  //////////////////////////////
  // Error responder
  //////////////////////////////

  // One cycle after valid, single pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else begin
      // Cleared on the ready cycle so a back-to-back request restarts
      err_q <= bus_req_i.valid && (tgt == TGT_NONE) && !err_q;
    end
  end

  //////////////////////////////
  // Response merge
  //////////////////////////////

  always_comb begin
    bus_rsp_o = '0;
    unique case (tgt)
      TGT_RAM: bus_rsp_o = ram_rsp_i;
      TGT_TIMER_LO,
      TGT_TIMER_HI: bus_rsp_o = timer_rsp_i;
      default: begin
        // Unmapped, rdata stays zero
        bus_rsp_o.ready = err_q;
        bus_rsp_o.err   = err_q;
      end
    endcase
  end

endmodule

//--- hdl/slow_ram_port.sv
`timescale 1ns/1ps

module slow_ram_port import soc_bus_pkg::*; #(
  parameter int RAM_WORDS = 1024,
  parameter int RAM_DELAY = 6
) (
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     sys_rst_n_i,
  input  logic     sel_i,
  input  bus_req_t bus_req_i,
  input  ram_wr_t  ram_wr_i,
  output bus_rsp_t rsp_o
);

  // Index bits actually used by the array
  localparam int AW = $clog2(RAM_WORDS);
  // Delay counter must reach RAM_DELAY
  localparam int DW = $clog2(RAM_DELAY + 1);

  data_t          mem [RAM_WORDS];
  logic [DW-1:0]  dly_q;
  logic           ready;
  ram_word_t      bus_word;
  logic [AW-1:0]  bus_idx;
  logic [AW-1:0]  ld_idx;

  // Word index from the byte address, upper bits wrap
  assign bus_word = ram_word_t'(bus_req_i.addr[17:2]);
  assign bus_idx  = bus_word[AW-1:0];
  assign ld_idx   = ram_wr_i.word[AW-1:0];

  //////////////////////////////
  // Response delay
  //////////////////////////////

  // Ready exactly RAM_DELAY cycles after the first valid cycle
  assign ready = sel_i && (dly_q == DW'(RAM_DELAY));

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      dly_q <= '0;
    end else if (!sys_rst_n_i) begin
      // Loader busy, request waits and counting restarts after load
      dly_q <= '0;
    end else if (sel_i) begin
      if (ready) begin
        // Back to zero after the ready pulse
        dly_q <= '0;
      end else begin
        dly_q <= dly_q + 1'b1;
      end
    end else begin
      dly_q <= '0;
    end
  end

  //////////////////////////////
  // Word array
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (ram_wr_i.en) begin
      // Loader wins over the bus
      mem[ld_idx] <= ram_wr_i.data;
    end else if (ready) begin
      // Strobed bytes only
      for (int b = 0; b < 4; b++) begin
        if (bus_req_i.wstrb[b]) begin
          mem[bus_idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Read returns the word as it was before this request's write
  always_comb begin
    rsp_o       = '0;
    rsp_o.ready = ready;
    if (ready) begin
      rsp_o.rdata = mem[bus_idx];
    end
  end

endmodule

//--- hdl/cycle_timer.sv
`timescale 1ns/1ps

module cycle_timer import soc_bus_pkg::*; (
  input  logic     clk_i,
  input  logic     sys_rst_n_i,
  input  logic     sel_i,
  input  logic     hi_i,
  output bus_rsp_t rsp_o
);

  // Free-running count of clocks since release
  logic [63:0] count_q;

  //////////////////////////////
  // Counter
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!sys_rst_n_i) begin
      // Held at zero, also during a program load
      count_q <= '0;
    end else begin
      count_q <= count_q + 64'd1;
    end
  end

  //////////////////////////////
  // Bus response
  //////////////////////////////

  // Zero wait states, answer in the valid cycle
  always_comb begin
    rsp_o       = '0;
    rsp_o.ready = sel_i;
    if (sel_i) begin
      if (hi_i) begin
        rsp_o.rdata = count_q[63:32];
      end else begin
        rsp_o.rdata = count_q[31:0];
      end
    end
  end

endmodule

//--- hdl/uart_program_loader.sv
`timescale 1ns/1ps

module uart_program_loader import soc_bus_pkg::*; #(
  parameter int CLKS_PER_BIT = 8
) (
  input  logic    clk_i,
  input  logic    rst_n,
  input  logic    prog_rx_i,
  output ram_wr_t ram_wr_o,
  output logic    sys_rst_n_o,
  output logic    busy_o
);

  localparam int CW = $clog2(CLKS_PER_BIT);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
  typedef enum logic [1:0] {F_IDLE, F_CNT_LO, F_CNT_HI, F_DATA} frame_state_e;

  logic [1:0]    rx_sync_q;
  logic          rx_bit;
  rx_state_e     rx_state_q;
  logic [CW-1:0] clk_cnt_q;
  logic [2:0]    bit_idx_q;
  logic [7:0]    shift_q;
  logic          byte_vld_q;

  frame_state_e  f_state_q;
  logic [7:0]    cnt_lo_q;
  ram_word_t     words_left_q;
  ram_word_t     word_idx_q;
  logic [1:0]    byte_idx_q;
  data_t         word_q;
  ram_wr_t       wr_q;

  //////////////////////////////
  // UART 8N1 receiver
  //////////////////////////////

  // Two flops against metastability, line idles high
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], prog_rx_i};
    end
  end
  assign rx_bit = rx_sync_q[1];

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rx_state_q <= RX_IDLE;
      clk_cnt_q  <= '0;
      bit_idx_q  <= '0;
      byte_vld_q <= 1'b0;
    end else begin
      byte_vld_q <= 1'b0;
      clk_cnt_q  <= clk_cnt_q + 1'b1;
      unique case (rx_state_q)
        RX_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx_bit) rx_state_q <= RX_START;
        end
        RX_START: begin
          // Half a bit in, start bit must still be low
          if (clk_cnt_q == CW'(CLKS_PER_BIT / 2 - 1)) begin
            clk_cnt_q  <= '0;
            bit_idx_q  <= '0;
            rx_state_q <= rx_bit ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          // Bit centres, LSB first
          if (clk_cnt_q == CW'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            shift_q   <= {rx_bit, shift_q[7:1]};
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) rx_state_q <= RX_STOP;
          end
        end
        default: begin
          // Byte kept only with a good stop bit
          if (clk_cnt_q == CW'(CLKS_PER_BIT - 1)) begin
            byte_vld_q <= rx_bit;
            rx_state_q <= RX_IDLE;
          end
        end
      endcase
    end
  end

  //////////////////////////////
  // Frame state machine
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      f_state_q <= F_IDLE;
      wr_q.en   <= 1'b0;
    end else begin
      wr_q.en <= 1'b0;
      unique case (f_state_q)
        F_IDLE: begin
          // Anything before the sync byte is dropped
          if (byte_vld_q && shift_q == LOAD_SYNC) begin
            f_state_q  <= F_CNT_LO;
            word_idx_q <= '0;
            byte_idx_q <= '0;
          end
        end
        F_CNT_LO: begin
          if (byte_vld_q) begin
            cnt_lo_q  <= shift_q;
            f_state_q <= F_CNT_HI;
          end
        end
        F_CNT_HI: begin
          if (byte_vld_q) begin
            words_left_q <= {shift_q, cnt_lo_q};
            // Empty frame closes at once
            f_state_q    <= ({shift_q, cnt_lo_q} == '0) ? F_IDLE : F_DATA;
          end
        end
        default: begin
          if (byte_vld_q) begin
            word_q     <= {shift_q, word_q[31:8]};
            byte_idx_q <= byte_idx_q + 1'b1;
            if (byte_idx_q == 2'd3) begin
              // Fourth byte completes the word
              wr_q.en      <= 1'b1;
              wr_q.word    <= word_idx_q;
              wr_q.data    <= {shift_q, word_q[31:8]};
              word_idx_q   <= word_idx_q + 1'b1;
              words_left_q <= words_left_q - 1'b1;
            end
          end
          // Leave one cycle after the last write
          if (wr_q.en && words_left_q == '0) f_state_q <= F_IDLE;
        end
      endcase
    end
  end

  assign ram_wr_o    = wr_q;
  assign busy_o      = (f_state_q != F_IDLE);
  // System stays in reset while a frame is open
  assign sys_rst_n_o = !busy_o;

endmodule

//--- hdl/soc_memory_top.sv
`timescale 1ns/1ps

module soc_memory_top import soc_bus_pkg::*; #(
  parameter int RAM_WORDS    = 1024,
  parameter int RAM_DELAY    = 6,
  parameter int CLKS_PER_BIT = 8
) (
  input  logic     clk_i,
  input  logic     rst_n,
  input  logic     prog_rx_i,
  input  bus_req_t bus_req_i,
  output bus_rsp_t bus_rsp_o,
  output logic     load_busy_o
);

  ram_wr_t  ram_wr;
  logic     ld_rel_n;
  logic     sys_rst_n;
  logic     ram_sel;
  logic     timer_sel;
  logic     timer_hi;
  bus_rsp_t ram_rsp;
  bus_rsp_t timer_rsp;

  //////////////////////////////
  // Program loader and reset
  //////////////////////////////

  // Loader runs on the board reset only
  uart_program_loader #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_loader (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .prog_rx_i   (prog_rx_i),
    .ram_wr_o    (ram_wr),
    .sys_rst_n_o (ld_rel_n),
    .busy_o      (load_busy_o)
  );

  // Rest of the system waits for both
  assign sys_rst_n = rst_n & ld_rel_n;

  //////////////////////////////
  // Decode and targets
  //////////////////////////////

  bus_decoder u_decoder (
    .clk_i       (clk_i),
    .rst_n       (sys_rst_n),
    .bus_req_i   (bus_req_i),
    .ram_sel_o   (ram_sel),
    .timer_sel_o (timer_sel),
    .timer_hi_o  (timer_hi),
    .ram_rsp_i   (ram_rsp),
    .timer_rsp_i (timer_rsp),
    .bus_rsp_o   (bus_rsp_o)
  );

  // RAM sees both resets so loader writes land while the bus is held
  slow_ram_port #(
    .RAM_WORDS (RAM_WORDS),
    .RAM_DELAY (RAM_DELAY)
  ) u_ram (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .sys_rst_n_i (sys_rst_n),
    .sel_i       (ram_sel),
    .bus_req_i   (bus_req_i),
    .ram_wr_i    (ram_wr),
    .rsp_o       (ram_rsp)
  );

  cycle_timer u_timer (
    .clk_i       (clk_i),
    .sys_rst_n_i (sys_rst_n),
    .sel_i       (timer_sel),
    .hi_i        (timer_hi),
    .rsp_o       (timer_rsp)
  );

endmodule

//--- bench/soc_memory_properties.sv
`timescale 1ns/1ps

module soc_memory_properties (
  input logic clk_i,
  input logic rst_n,
  input logic sel_i,
  input logic ready_i,
  input logic err_i,
  input logic hold_i
);

  // Failed assertions so far
  int unsigned fail_count = 0;

  //////////////////////////////
  // RAM handshake
  //////////////////////////////

  // RAM ready is a single pulse per request
  ram_ready_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    (sel_i && ready_i) |=> !ready_i
  ) else begin
    $error("RAM ready stayed high for more than one cycle");
    fail_count++;
  end

  // Error response never for a RAM access
  ram_never_err: assert property (
    @(posedge clk_i) !(sel_i && err_i)
  ) else begin
    $error("Error response raised together with the RAM select");
    fail_count++;
  end

  // Nothing from the RAM while the loader holds the system
  ram_quiet_in_load: assert property (
    @(posedge clk_i) hold_i |-> !(sel_i && ready_i)
  ) else begin
    $error("RAM ready seen while the program loader was busy");
    fail_count++;
  end

endmodule

// RAM side, hold is the system reset from the loader
bind slow_ram_port soc_memory_properties ram_props (
  .clk_i   (clk_i),
  .rst_n   (rst_n),
  .sel_i   (sel_i),
  .ready_i (rsp_o.ready),
  .err_i   (rsp_o.err),
  .hold_i  (!sys_rst_n_i)
);

// Decoder side, its reset already is the system reset
bind bus_decoder soc_memory_properties dec_props (
  .clk_i   (clk_i),
  .rst_n   (rst_n),
  .sel_i   (ram_sel_o),
  .ready_i (bus_rsp_o.ready),
  .err_i   (bus_rsp_o.err),
  .hold_i  (!rst_n)
);

//--- bench/soc_memory_tb.sv
`timescale 1ns/1ps

module soc_memory_tb import soc_bus_pkg::*; ();

  localparam int RAM_WORDS    = 1024;
  localparam int RAM_DELAY    = 6;
  localparam int CLKS_PER_BIT = 8;
  localparam int CLK_PERIOD   = 40;
  localparam int LOAD_WORDS   = 16;

  // Junk byte plus two frames, the second one two words long
  localparam int FRAME_BYTES  = 1 + 3 + 4 * LOAD_WORDS + 3 + 4 * 2;
  // Start, 8 data, stop, idle bit and the aligning edge
  localparam int BYTE_CYCLES  = 11 * CLKS_PER_BIT + 1;
  // Bus operations over all tests, rounded up
  localparam int BUS_OPS      = 96;
  localparam int TEST_CYCLES  = FRAME_BYTES * BYTE_CYCLES + BUS_OPS * (RAM_DELAY + 4) + 200;
  // Longest legal wait, a request held through a whole load
  localparam int MAX_WAIT     = 16 * BYTE_CYCLES;

  logic        clk_i;
  logic        rst_n;
  logic        prog_rx;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        load_busy;

  integer      seed = 75;
  int unsigned cycle_count;
  data_t       ram_model [int];
  data_t       frame_words [LOAD_WORDS];
  // Taken on the ready cycle of the last access
  logic        busy_at_ready;
  int unsigned ready_stamp;
  // Pending data results for the comparing process
  string       name_q [$];
  data_t       exp_q [$];
  data_t       act_q [$];

  soc_memory_top #(
    .RAM_WORDS    (RAM_WORDS),
    .RAM_DELAY    (RAM_DELAY),
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_dut (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .prog_rx_i   (prog_rx),
    .bus_req_i   (bus_req),
    .bus_rsp_o   (bus_rsp),
    .load_busy_o (load_busy)
  );

  //////////////////////////////
  // Clock, cycle count, watchdog
  //////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clk_i);
      cycle_count++;
    end
  end

  initial begin
    repeat (2 * TEST_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not finish", 2 * TEST_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_cycles(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("[FAIL] %s: expected %0d cycles, actual %0d cycles", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic queue_compare(input string name, input data_t exp, input data_t act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  function automatic int count_assertion_failures();
    return int'(u_dut.u_ram.ram_props.fail_count + u_dut.u_decoder.dec_props.fail_count);
  endfunction

  // Drains the result queues once per cycle
  initial begin
    forever begin
      @(negedge clk_i);
      while (act_q.size() > 0) begin
        check_data(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
      end
      if (count_assertion_failures() != 0) begin
        $display("A concurrent assertion failed, see the error above");
        stop_on_error();
      end
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic int word_of(input addr_t addr);
    return int'((addr - RAM_BASE) >> 2);
  endfunction

  // Read returns the word before this request's write
  function automatic data_t expected_read(input addr_t addr);
    return ram_model[word_of(addr)];
  endfunction

  task automatic model_write(input addr_t addr, input strb_t strb, input data_t wdata);
    data_t w;
    w = ram_model[word_of(addr)];
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        w[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    ram_model[word_of(addr)] = w;
  endtask

  //////////////////////////////
  // UART and bus drivers
  //////////////////////////////

  // 8N1, LSB first, one idle bit after the stop bit
  task automatic uart_send(input logic [7:0] value);
    logic [9:0] frame;
    frame = {1'b1, value, 1'b0};
    @(negedge clk_i);
    for (int i = 0; i < 10; i++) begin
      prog_rx = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk_i);
    end
    repeat (CLKS_PER_BIT) @(negedge clk_i);
  endtask

  task automatic send_header(input ram_word_t count);
    uart_send(LOAD_SYNC);
    uart_send(count[7:0]);
    uart_send(count[15:8]);
  endtask

  task automatic send_words(input int n);
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < 4; b++) begin
        uart_send(frame_words[i][8*b +: 8]);
      end
    end
  endtask

  // One transfer, waited counts the cycles with ready low
  task automatic bus_access(input addr_t addr, input strb_t strb, input data_t wdata,
                            output data_t rdata, output logic err, output int waited);
    int n;
    n = 0;
    @(negedge clk_i);
    bus_req.valid = 1'b1;
    bus_req.wstrb = strb;
    bus_req.addr  = addr;
    bus_req.wdata = wdata;
    // Sample mid low phase, away from both edges
    #(CLK_PERIOD / 4);
    while (!bus_rsp.ready) begin
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
      n++;
      if (n > MAX_WAIT) begin
        $display("Bus request to 0x%08h got no ready within %0d cycles", addr, MAX_WAIT);
        stop_on_error();
      end
    end
    rdata         = bus_rsp.rdata;
    err           = bus_rsp.err;
    waited        = n;
    busy_at_ready = load_busy;
    ready_stamp   = cycle_count;
    // Transfer completes at the coming rising edge
    @(negedge clk_i);
    bus_req = '0;
  endtask

  task automatic read_all_words(input string tag);
    data_t rdata;
    logic  err;
    int    waited;
    for (int i = 0; i < LOAD_WORDS; i++) begin
      bus_access(RAM_BASE + addr_t'(4 * i), '0, '0, rdata, err, waited);
      queue_compare($sformatf("%s word %0d", tag, i),
                    expected_read(RAM_BASE + addr_t'(4 * i)), rdata);
      check_flag($sformatf("%s word %0d err", tag, i), 1'b0, err);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    data_t       rdata;
    data_t       t_first;
    logic        err;
    int          waited;
    int          idx;
    int          gap;
    strb_t       strb;
    data_t       wdata;
    int unsigned stamp;

    rst_n   = 1'b0;
    prog_rx = 1'b1;
    bus_req = '0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    // Outputs idle out of reset
    check_flag("ready after reset", 1'b0, bus_rsp.ready);
    check_flag("err after reset", 1'b0, bus_rsp.err);
    check_flag("busy after reset", 1'b0, load_busy);
    rst_n = 1'b1;

    // Program load, junk before the sync byte
    uart_send(8'h33);
    for (int i = 0; i < LOAD_WORDS; i++) begin
      frame_words[i] = $random(seed);
    end
    send_header(ram_word_t'(LOAD_WORDS));
    check_flag("busy after sync", 1'b1, load_busy);
    send_words(LOAD_WORDS);
    while (load_busy) begin
      @(negedge clk_i);
    end
    for (int i = 0; i < LOAD_WORDS; i++) begin
      ram_model[i] = frame_words[i];
    end
    read_all_words("load");

    // RAM latency, then a request held through a second load
    bus_access(RAM_BASE + 32'h24, '0, '0, rdata, err, waited);
    check_cycles("ram read latency", RAM_DELAY, waited);
    queue_compare("ram read word 9", expected_read(RAM_BASE + 32'h24), rdata);
    frame_words[0] = $random(seed);
    frame_words[1] = $random(seed);
    fork
      begin
        send_header(ram_word_t'(2));
        send_words(2);
      end
      begin
        while (!load_busy) begin
          @(negedge clk_i);
        end
        bus_access(RAM_BASE, '0, '0, rdata, err, waited);
      end
    join
    check_flag("request held through load", 1'b0, busy_at_ready);
    ram_model[0] = frame_words[0];
    ram_model[1] = frame_words[1];
    queue_compare("read after reload", expected_read(RAM_BASE), rdata);

    // Random byte strobes, zero strobes read
    for (int i = 0; i < 24; i++) begin
      idx   = $random(seed) & 15;
      strb  = strb_t'($random(seed));
      wdata = $random(seed);
      bus_access(RAM_BASE + addr_t'(4 * idx), strb, wdata, rdata, err, waited);
      queue_compare($sformatf("strobe op %0d", i),
                    expected_read(RAM_BASE + addr_t'(4 * idx)), rdata);
      model_write(RAM_BASE + addr_t'(4 * idx), strb, wdata);
    end
    read_all_words("strobe");

    // Timer halves
    bus_access(TIMER_LO_ADDR, '0, '0, t_first, err, waited);
    check_cycles("timer latency", 0, waited);
    stamp = ready_stamp;
    gap   = 3 + ($random(seed) & 15);
    repeat (gap) @(negedge clk_i);
    bus_access(TIMER_LO_ADDR, '0, '0, rdata, err, waited);
    queue_compare("timer low delta", data_t'(ready_stamp - stamp), rdata - t_first);
    bus_access(TIMER_HI_ADDR, '0, '0, rdata, err, waited);
    queue_compare("timer high", '0, rdata);

    // Unmapped, one just past the RAM window
    bus_access(TIMER_LO_ADDR, '0, '0, t_first, err, waited);
    stamp = ready_stamp;
    bus_access(32'h4010_0000, 4'hF, 32'hDEAD_BEEF, rdata, err, waited);
    check_flag("unmapped write err", 1'b1, err);
    check_cycles("unmapped latency", 1, waited);
    queue_compare("unmapped write rdata", '0, rdata);
    bus_access(32'h3000_0008, '0, '0, rdata, err, waited);
    check_flag("unmapped read err", 1'b1, err);
    queue_compare("unmapped read rdata", '0, rdata);
    bus_access(TIMER_LO_ADDR, '0, '0, rdata, err, waited);
    queue_compare("timer after unmapped", data_t'(ready_stamp - stamp), rdata - t_first);
    read_all_words("unmapped");

    while (act_q.size() != 0) begin
      @(negedge clk_i);
    end
    if (count_assertion_failures() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("Concurrent assertions failed %0d times", count_assertion_failures());
      stop_on_error();
    end
  end

endmodule

//--- soc_memory.f
hdl/soc_bus_pkg.sv
hdl/bus_decoder.sv
hdl/slow_ram_port.sv
hdl/cycle_timer.sv
hdl/uart_program_loader.sv
hdl/soc_memory_top.sv
bench/soc_memory_properties.sv
bench/soc_memory_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_memory_tb \
  -f soc_memory.f -o soc_memory_sim > build.log 2>&1 \
  && ./obj_dir/soc_memory_sim > sim.log 2>&1 \
  || cat build.log
cat sim.log 2>/dev/null
grep -q "TEST PASSED" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
